//--- common/s16b_pkg.sv
// System 16B main bus definitions
package s16b_pkg;

    // Mapper regions, in priority order
    typedef enum logic [2:0] {
        REG_ROM0,
        REG_ROM1,
        REG_ROM2,
        REG_RAM,
        REG_ORAM,
        REG_VRAM,
        REG_PAL,
        REG_IO
    } region_e;

    // Region size codes
    typedef enum logic [2:0] {
        SIZE_64K,
        SIZE_128K,
        SIZE_256K,
        SIZE_512K,
        SIZE_OFF    // Region disabled
    } size_e;

    // I/O groups at address bits 13:12
    typedef enum logic [1:0] {
        IO_CTRL,
        IO_INPUTS,
        IO_DIPS,
        IO_NONE
    } io_grp_e;

    localparam logic [7:0]  MAPPER_PAGE   = 8'hFF;
    localparam int          UNMAPPED_WAIT = 4;
    localparam logic [15:0] OPEN_BUS      = 16'hFFFF;

    // Default map after reset
    localparam logic [7:0] RESET_BASE [8] = '{8'h00, 8'h04, 8'h00, 8'hFE,
                                              8'h44, 8'h40, 8'h84, 8'hC4};
    localparam size_e RESET_SIZE [8] = '{SIZE_256K, SIZE_256K, SIZE_OFF, SIZE_64K,
                                         SIZE_64K, SIZE_128K, SIZE_64K, SIZE_64K};

endpackage

//--- hdl/s16b_cab_io.sv
// Cabinet inputs and video control registers
`timescale 1ns/1ns

module s16b_cab_io import s16b_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        io_cs,
    input  logic        tbank_cs,
    input  logic [13:1] addr,
    input  logic [7:0]  cpu_dout,
    input  logic        ldswn,
    input  logic [7:0]  joystick1,
    input  logic [7:0]  joystick2,
    input  logic [1:0]  start_button,
    input  logic [1:0]  coin_input,
    input  logic        service,
    input  logic        dip_test,
    input  logic [7:0]  dipsw_a,
    input  logic [7:0]  dipsw_b,
    output logic [7:0]  cab_dout,
    output logic        flip,
    output logic        video_en,
    output logic [5:0]  tile_bank
);

    io_grp_e grp;

    assign grp = io_grp_e'(addr[13:12]);

    // Board wiring of the joystick lines
    function automatic logic [7:0] sort_joy(input logic [7:0] joy);
        sort_joy = {joy[1], joy[0], joy[3], joy[2], joy[7], joy[5], joy[4], joy[6]};
    endfunction

    // Cabinet read data
    always_comb begin
        cab_dout = 8'hFF;
        case (grp)
            IO_INPUTS: begin
                case (addr[2:1])
                    2'd0:    cab_dout = {2'b11, start_button, service, dip_test, coin_input};
                    2'd1:    cab_dout = sort_joy(joystick1);
                    2'd3:    cab_dout = sort_joy(joystick2);
                    default: cab_dout = 8'hFF;
                endcase
            end
            IO_DIPS:          cab_dout = addr[1] ? dipsw_a : dipsw_b;
            IO_CTRL, IO_NONE: cab_dout = 8'hFF;
            default:          cab_dout = 8'hFF;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flip     <= 1'b0;
            video_en <= 1'b1;    // Screen on out of reset
        end else if (io_cs && !ldswn && grp == IO_CTRL) begin
            flip     <= cpu_dout[6];
            video_en <= cpu_dout[5];
        end
    end

    // Tile bank, written three bits at a time
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            tile_bank <= 6'd0;
        end else if (tbank_cs && !ldswn) begin
            if (addr[1]) begin
                tile_bank[5:3] <= cpu_dout[2:0];
            end else begin
                tile_bank[2:0] <= cpu_dout[2:0];
            end
        end
    end

endmodule

//--- hdl/s16b_dtack.sv
// Bus acknowledge generator
`timescale 1ns/1ns

module s16b_dtack import s16b_pkg::*; (
    input  logic clk,
    input  logic rst,
    input  logic asn,
    input  logic bus_cs,
    input  logic bus_busy,
    output logic dtackn
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT,
        ACK
    } state_e;

    state_e     state;
    logic [2:0] cnt;    // Cycles without a chip select

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= IDLE;
            cnt   <= 3'd0;
        end else begin
            case (state)
                IDLE: begin
                    cnt <= 3'd0;
                    if (!asn) state <= WAIT;
                end
                WAIT: begin
                    if (asn) begin
                        state <= IDLE;
                    end else if (bus_cs && !bus_busy) begin
                        state <= ACK;
                    end else if (!bus_cs) begin
                        // Nothing answers, acknowledge anyway
                        if (cnt == 3'(UNMAPPED_WAIT - 1)) state <= ACK;
                        else cnt <= cnt + 3'd1;
                    end
                end
                ACK: if (asn) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    assign dtackn = (state != ACK);

    a_dtack_release: assert property (
        @(posedge clk) disable iff (rst)
        asn && $past(asn) |-> dtackn
    ) else $error("dtackn held low after address strobe release");

endmodule

//--- hdl/s16b_main.sv
// System 16B main CPU bus glue
`timescale 1ns/1ns

module s16b_main (
    input  logic        clk,
    input  logic        rst,
    // CPU bus
    input  logic [23:1] addr,
    input  logic [15:0] cpu_dout,
    input  logic        rnw,
    input  logic        asn,
    input  logic        udsn,
    input  logic        ldsn,
    output logic [15:0] cpu_din,
    output logic        dtackn,
    output logic        udswn,
    output logic        ldswn,
    // ROM and RAM
    output logic        rom_cs,
    output logic [18:1] rom_addr,
    input  logic [15:0] rom_data,
    input  logic        rom_ok,
    output logic        ram_cs,
    output logic        vram_cs,
    input  logic [15:0] ram_data,
    input  logic        ram_ok,
    // Video
    output logic        char_cs,
    output logic        pal_cs,
    output logic        objram_cs,
    input  logic [15:0] char_dout,
    input  logic [15:0] pal_dout,
    input  logic [15:0] obj_dout,
    output logic        flip,
    output logic        video_en,
    output logic [5:0]  tile_bank,
    // Cabinet
    input  logic [7:0]  joystick1,
    input  logic [7:0]  joystick2,
    input  logic [1:0]  start_button,
    input  logic [1:0]  coin_input,
    input  logic        service,
    input  logic        dip_test,
    input  logic [7:0]  dipsw_a,
    input  logic [7:0]  dipsw_b
);

    logic       busn, io_cs, tbank_cs, bus_cs, bus_busy;
    logic [7:0] active, cab_dout;

    assign udswn = rnw | udsn;
    assign ldswn = rnw | ldsn;
    assign busn  = asn | (udsn & ldsn);    // Any data strobe in a bus cycle

    s16b_mapper u_mapper (.clk, .rst, .addr, .cpu_dout(cpu_dout[7:0]), .asn, .ldswn, .active);

    s16b_memmap u_memmap (
        .clk, .rst, .active, .addr(addr[18:1]), .asn, .busn, .rnw, .rom_ok, .ram_ok,
        .ram_data, .rom_data, .char_dout, .pal_dout, .obj_dout, .cab_dout,
        .rom_cs, .ram_cs, .vram_cs, .char_cs, .objram_cs, .pal_cs, .io_cs, .tbank_cs,
        .rom_addr, .cpu_din, .bus_cs, .bus_busy
    );

    s16b_cab_io u_cab_io (
        .clk, .rst, .io_cs, .tbank_cs, .addr(addr[13:1]), .cpu_dout(cpu_dout[7:0]), .ldswn,
        .joystick1, .joystick2, .start_button, .coin_input, .service, .dip_test,
        .dipsw_a, .dipsw_b, .cab_dout, .flip, .video_en, .tile_bank
    );

    s16b_dtack u_dtack (.clk, .rst, .asn, .bus_cs, .bus_busy, .dtackn);

endmodule

//--- hdl/s16b_memmap.sv
// Memory map chip selects and read data
`timescale 1ns/1ns

module s16b_memmap import s16b_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [7:0]  active,
    input  logic [18:1] addr,
    input  logic        asn,
    input  logic        busn,
    input  logic        rnw,
    input  logic        rom_ok,
    input  logic        ram_ok,
    input  logic [15:0] ram_data,
    input  logic [15:0] rom_data,
    input  logic [15:0] char_dout,
    input  logic [15:0] pal_dout,
    input  logic [15:0] obj_dout,
    input  logic [7:0]  cab_dout,
    output logic        rom_cs,
    output logic        ram_cs,
    output logic        vram_cs,
    output logic        char_cs,
    output logic        objram_cs,
    output logic        pal_cs,
    output logic        io_cs,
    output logic        tbank_cs,
    output logic [18:1] rom_addr,
    output logic [15:0] cpu_din,
    output logic        bus_cs,
    output logic        bus_busy
);

    assign rom_addr = addr;    // No banking on ROM

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            {rom_cs, ram_cs, vram_cs, char_cs} <= 4'b0000;
            {objram_cs, pal_cs, io_cs, tbank_cs} <= 4'b0000;
        end else if (!asn) begin
            rom_cs    <= |active[REG_ROM2:REG_ROM0] && rnw;
            tbank_cs  <= active[REG_ROM2] && !rnw;
            char_cs   <= active[REG_VRAM] && addr[16];
            // busn toggles between halves of a read-modify-write
            vram_cs   <= !busn && active[REG_VRAM] && !addr[16];
            ram_cs    <= !busn && active[REG_RAM];
            objram_cs <= active[REG_ORAM];
            pal_cs    <= active[REG_PAL];
            io_cs     <= active[REG_IO];
        end else begin
            {rom_cs, ram_cs, vram_cs, char_cs} <= 4'b0000;
            {objram_cs, pal_cs, io_cs, tbank_cs} <= 4'b0000;
        end
    end

    // Read data capture
    always_ff @(posedge clk) begin
        if (ram_cs || vram_cs) cpu_din <= ram_data;
        else if (rom_cs)       cpu_din <= rom_data;
        else if (char_cs)      cpu_din <= char_dout;
        else if (pal_cs)       cpu_din <= pal_dout;
        else if (objram_cs)    cpu_din <= obj_dout;
        else if (io_cs)        cpu_din <= {8'hFF, cab_dout};
        else if (!asn)         cpu_din <= OPEN_BUS;    // Unmapped access
    end

    assign bus_cs   = rom_cs | ram_cs | vram_cs | char_cs | objram_cs | pal_cs | io_cs | tbank_cs;
    assign bus_busy = (rom_cs && !rom_ok) || ((ram_cs || vram_cs) && !ram_ok);

    a_data_sel: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0({rom_cs, ram_cs, vram_cs, char_cs, objram_cs, pal_cs, io_cs})
    ) else $error("More than one data select active");

endmodule

//--- list.f
common/s16b_pkg.sv
mapper/s16b_mapper.sv
hdl/s16b_memmap.sv
hdl/s16b_cab_io.sv
hdl/s16b_dtack.sv
hdl/s16b_main.sv
testbench/tb_s16b_main.sv

//--- mapper/s16b_mapper.sv
// Programmable region mapper
`timescale 1ns/1ns

module s16b_mapper import s16b_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic [23:1] addr,
    input  logic [7:0]  cpu_dout,
    input  logic        asn,
    input  logic        ldswn,
    output logic [7:0]  active
);

    logic [7:0] reg_base [8];
    size_e      reg_size [8];
    logic [7:0] match;
    logic       map_page;
    region_e    sel;

    assign map_page = (addr[23:16] == MAPPER_PAGE);
    assign sel      = region_e'(addr[4:2]);    // Register group index

    // Address bits kept in the compare for each size
    function automatic logic [7:0] size_mask(input size_e sz);
        case (sz)
            SIZE_64K:  size_mask = 8'hFF;
            SIZE_128K: size_mask = 8'hFE;
            SIZE_256K: size_mask = 8'hFC;
            SIZE_512K: size_mask = 8'hF8;
            default:   size_mask = 8'h00;
        endcase
    endfunction

    // Register writes in the mapper page
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 8; i++) begin
                reg_base[i] <= RESET_BASE[i];
                reg_size[i] <= RESET_SIZE[i];
            end
        end else if (!asn && !ldswn && map_page) begin
            if (addr[1]) begin
                reg_size[sel] <= size_e'(cpu_dout[2:0]);    // Unknown codes act as off
            end else begin
                reg_base[sel] <= cpu_dout;
            end
        end
    end

    // Per-region compare of the upper address byte
    always_comb begin
        for (int i = 0; i < 8; i++) begin
            match[i] = (reg_size[i] < SIZE_OFF) &&
                       (((addr[23:16] ^ reg_base[i]) & size_mask(reg_size[i])) == 8'h00);
        end
    end

    // Lowest matching region wins
    always_comb begin
        if (map_page) begin
            active = 8'h00;
        end else begin
            active = match & (~match + 8'd1);    // Isolate lowest set bit
        end
    end

    a_active_onehot: assert property (
        @(posedge clk) disable iff (rst)
        !asn && $past(!asn) |-> $onehot0(active) && $stable(active)
    ) else $error("Mapper active set not one-hot or changed mid-access");

endmodule

//--- testbench/tb_s16b_main.sv
// System 16B bus glue testbench
`timescale 1ns/1ns

module tb_s16b_main import s16b_pkg::*; ();

    localparam logic [1:0] OP_RD = 2'd0;
    localparam logic [1:0] OP_WR = 2'd1;
    localparam logic [1:0] OP_ST = 2'd2;    // Compare flip, video_en, tile_bank
    localparam int         BUS_LIMIT = UNMAPPED_WAIT + 12;

    typedef struct packed {
        logic [1:0]  op;
        logic [23:0] badr;
        logic [15:0] data;
        logic [1:0]  strb;    // Byte enables for upper and lower
        logic [15:0] exp;
    } row_t;

    logic        clk, rst, rnw, asn, udsn, ldsn, rom_ok, ram_ok, service, dip_test;
    logic [23:1] addr;
    logic [15:0] cpu_dout, cpu_din, rom_data, ram_data, char_dout, pal_dout, obj_dout;
    logic        dtackn, udswn, ldswn, rom_cs, ram_cs, vram_cs, char_cs, pal_cs, objram_cs;
    logic [18:1] rom_addr;
    logic        flip, video_en;
    logic [5:0]  tile_bank;
    logic [7:0]  joystick1, joystick2, dipsw_a, dipsw_b;
    logic [1:0]  start_button, coin_input;
    logic [15:0] ram_mem [65536];
    logic [15:0] vram_mem [65536];
    logic [31:0] lfsr = 32'he726_efc3;
    row_t        rows [$];

    s16b_main DUT (.*);

    always #20 clk = ~clk;

    // Memory models drive data only while selected and ready
    assign rom_data  = (rom_cs && rom_ok) ? (rom_addr[16:1] ^ 16'hA5A5) : 16'hxxxx;
    assign ram_data  = !ram_ok ? 16'hxxxx :
                       ram_cs  ? ram_mem[addr[16:1]] :
                       vram_cs ? vram_mem[addr[16:1]] : 16'hxxxx;
    assign char_dout = char_cs   ? 16'h1234 : 16'hxxxx;
    assign pal_dout  = pal_cs    ? 16'h5678 : 16'hxxxx;
    assign obj_dout  = objram_cs ? 16'h9ABC : 16'hxxxx;

    always @(posedge clk) begin
        if (ram_ok && ram_cs) begin
            if (!udswn) ram_mem[addr[16:1]][15:8] <= cpu_dout[15:8];
            if (!ldswn) ram_mem[addr[16:1]][7:0]  <= cpu_dout[7:0];
        end
        if (ram_ok && vram_cs) begin
            if (!udswn) vram_mem[addr[16:1]][15:8] <= cpu_dout[15:8];
            if (!ldswn) vram_mem[addr[16:1]][7:0]  <= cpu_dout[7:0];
        end
    end

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        lfsr_step = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_wait(output int w);
        lfsr = lfsr_step(lfsr);
        w = lfsr[0];
        lfsr = lfsr_step(lfsr);
        w = 2 * w + lfsr[0];    // 0 to 3 cycles
    endtask

    task automatic stop_on_error(input string line);
        $display("%s", line);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic add_row(input logic [1:0] op, input logic [23:0] a, input logic [15:0] d,
                           input logic [1:0] s, input logic [15:0] e);
        row_t r;
        r.op = op;
        r.badr = a;
        r.data = d;
        r.strb = s;
        r.exp = e;
        rows.push_back(r);
    endtask

    // One CPU bus cycle ended by dtackn
    task automatic bus_cycle(input logic wr, input logic [23:0] badr, input logic [15:0] data,
                             input logic [1:0] strb, output logic [15:0] rdata);
        int rom_wait, ram_wait, n;
        draw_wait(rom_wait);
        draw_wait(ram_wait);
        @(negedge clk);
        addr     = badr[23:1];
        cpu_dout = data;
        rnw      = !wr;
        udsn     = !strb[1];
        ldsn     = !strb[0];
        asn      = 1'b0;
        rom_ok   = (rom_wait == 0);
        ram_ok   = (ram_wait == 0);
        n = 0;
        while (dtackn) begin
            @(negedge clk);
            n++;
            if (n >= rom_wait) rom_ok = 1'b1;
            if (n >= ram_wait) ram_ok = 1'b1;
            assert (n <= BUS_LIMIT) else
                stop_on_error($sformatf("No dtackn for the access at %06h", badr));
        end
        rdata = cpu_din;
        {asn, udsn, ldsn, rnw, rom_ok, ram_ok} = 6'b111111;    // Release the bus
    endtask

    initial begin
        logic [15:0] rdata;
        clk = 1'b0;
        rst = 1'b1;
        {asn, udsn, ldsn, rnw, rom_ok, ram_ok} = 6'b111111;
        addr = '0;
        cpu_dout = 16'h0000;
        joystick1 = 8'hB2;
        joystick2 = 8'h4D;
        start_button = 2'b10;
        coin_input = 2'b01;
        service = 1'b1;
        dip_test = 1'b0;
        dipsw_a = 8'h5A;
        dipsw_b = 8'hC3;
        for (int i = 0; i < 65536; i++) begin
            ram_mem[i]  = 16'(i) ^ 16'h3C3C;
            vram_mem[i] = {8'(i), 8'(i >> 8)} ^ 16'h5A5A;
        end

        add_row(OP_ST, 24'h000000, 16'h0000, 2'b00, 16'h0040);    // Reset state
        add_row(OP_RD, 24'h000010, 16'h0000, 2'b11, 16'h0008 ^ 16'hA5A5);
        add_row(OP_RD, 24'h07FFFE, 16'h0000, 2'b11, 16'hFFFF ^ 16'hA5A5);
        add_row(OP_RD, 24'hFE0100, 16'h0000, 2'b11, 16'h0080 ^ 16'h3C3C);
        add_row(OP_RD, 24'h410000, 16'h0000, 2'b11, 16'h1234);
        add_row(OP_RD, 24'h840000, 16'h0000, 2'b11, 16'h5678);
        add_row(OP_RD, 24'h440000, 16'h0000, 2'b11, 16'h9ABC);
        add_row(OP_RD, 24'h400020, 16'h0000, 2'b11, 16'h1000 ^ 16'h5A5A);
        add_row(OP_RD, 24'h200000, 16'h0000, 2'b11, OPEN_BUS);
        // Byte merges in RAM and VRAM
        add_row(OP_WR, 24'hFE0200, 16'hBEEF, 2'b10, 16'h0000);
        add_row(OP_WR, 24'hFE0200, 16'h1177, 2'b01, 16'h0000);
        add_row(OP_RD, 24'hFE0200, 16'h0000, 2'b11, 16'hBE77);
        add_row(OP_WR, 24'hFE0204, 16'hCAFE, 2'b11, 16'h0000);
        add_row(OP_RD, 24'hFE0204, 16'h0000, 2'b11, 16'hCAFE);
        add_row(OP_WR, 24'h400020, 16'h00AB, 2'b01, 16'h0000);
        add_row(OP_RD, 24'h400020, 16'h0000, 2'b11, 16'h4AAB);
        // Cabinet inputs and DIPs
        add_row(OP_RD, 24'hC41000, 16'h0000, 2'b11, 16'hFFE9);
        add_row(OP_RD, 24'hC41002, 16'h0000, 2'b11, 16'hFF8E);
        add_row(OP_RD, 24'hC41006, 16'h0000, 2'b11, 16'hFF71);
        add_row(OP_RD, 24'hC41004, 16'h0000, 2'b11, 16'hFFFF);
        add_row(OP_RD, 24'hC42000, 16'h0000, 2'b11, 16'hFFC3);
        add_row(OP_RD, 24'hC42002, 16'h0000, 2'b11, 16'hFF5A);
        // Control group writes then tile bank through ROM2 mapped at 30
        add_row(OP_WR, 24'hC40000, 16'h0040, 2'b01, 16'h0000);
        add_row(OP_ST, 24'h000000, 16'h0000, 2'b00, 16'h0080);
        add_row(OP_WR, 24'hC40000, 16'h0020, 2'b01, 16'h0000);
        add_row(OP_ST, 24'h000000, 16'h0000, 2'b00, 16'h0040);
        add_row(OP_WR, 24'hFF0008, 16'h0030, 2'b01, 16'h0000);
        add_row(OP_WR, 24'hFF000A, 16'h0000, 2'b01, 16'h0000);
        add_row(OP_WR, 24'h300000, 16'h0005, 2'b01, 16'h0000);
        add_row(OP_WR, 24'h300002, 16'h0003, 2'b01, 16'h0000);
        add_row(OP_ST, 24'h000000, 16'h0000, 2'b00, 16'h005D);
        // RAM moved from FE to 20
        add_row(OP_WR, 24'hFF000C, 16'h0020, 2'b01, 16'h0000);
        add_row(OP_RD, 24'h200100, 16'h0000, 2'b11, 16'h0080 ^ 16'h3C3C);
        add_row(OP_RD, 24'h200200, 16'h0000, 2'b11, 16'hBE77);
        add_row(OP_RD, 24'hFE0100, 16'h0000, 2'b11, OPEN_BUS);

        repeat (2) @(posedge clk);
        @(negedge clk) rst = 1'b0;

        for (int i = 0; i < rows.size(); i++) begin
            if (rows[i].op == OP_ST) begin
                @(negedge clk);
                rdata = {8'h00, flip, video_en, tile_bank};
            end else begin
                bus_cycle(rows[i].op == OP_WR, rows[i].badr, rows[i].data, rows[i].strb, rdata);
            end
            if (rows[i].op != OP_WR) begin
                assert (rdata === rows[i].exp) else
                    stop_on_error($sformatf("Mismatch at %0t: row %0d addr %06h got %04h exp %04h",
                        $time, i, rows[i].badr, rdata, rows[i].exp));
            end
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule
